// File: design/addr_translate.sv
`include "mmu_cfg.svh"

module addr_translate (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                in_valid_i,
    input  mmu_pkg::xlat_req_t                  in_req_i,
    // csr levels
    input  logic                                csr_da_i,
    input  logic                                csr_pg_i,
    input  logic [31:0]                         csr_dmw0_i,
    input  logic [31:0]                         csr_dmw1_i,
    input  logic [9:0]                          asid_i,
    // tlb maintenance
    input  logic                                tlb_we_i,
    input  logic [$clog2(`MMU_TLB_ENTRIES)-1:0] tlb_w_index_i,
    input  mmu_pkg::tlb_entry_t                 tlb_w_entry_i,
    input  logic                                inv_en_i,
    input  logic [4:0]                          inv_op_i,
    input  logic [9:0]                          inv_asid_i,
    input  logic [31:0]                         inv_vaddr_i,
    output logic                                out_valid_o,
    output mmu_pkg::xlat_resp_t                 out_resp_o
);

    logic                pg_mode;
    logic                dmw0_hit;
    logic                dmw1_hit;
    logic                tlb_found;
    logic [5:0]          tlb_ps;
    logic [19:0]         tlb_ppn;
    logic                tlb_v;
    logic                tlb_d;
    logic [1:0]          tlb_plv;
    logic [31:0]         tlb_paddr;
    mmu_pkg::xlat_resp_t resp_d;
    logic                out_valid_q;
    mmu_pkg::xlat_resp_t out_resp_q;

    // windows only open for plv 0 or plv 3
    function automatic logic dmw_hit(logic [31:0] dmw, logic [31:0] va, logic [1:0] plv);
        logic plv_ok;
        plv_ok = ((plv == 2'd0) && dmw[`MMU_DMW_PLV0]) || ((plv == 2'd3) && dmw[`MMU_DMW_PLV3]);
        return plv_ok && (dmw[`MMU_DMW_VSEG] == va[31:29]);
    endfunction

    assign pg_mode  = csr_pg_i && !csr_da_i;
    assign dmw0_hit = dmw_hit(csr_dmw0_i, in_req_i.vaddr, in_req_i.plv);
    assign dmw1_hit = dmw_hit(csr_dmw1_i, in_req_i.vaddr, in_req_i.plv);

    tlb_array tlb_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .s_vaddr_i  (in_req_i.vaddr),
        .s_asid_i   (asid_i),
        .s_found_o  (tlb_found),
        .s_ps_o     (tlb_ps),
        .s_ppn_o    (tlb_ppn),
        .s_v_o      (tlb_v),
        .s_d_o      (tlb_d),
        .s_plv_o    (tlb_plv),
        .we_i       (tlb_we_i),
        .w_index_i  (tlb_w_index_i),
        .w_entry_i  (tlb_w_entry_i),
        .inv_en_i   (inv_en_i),
        .inv_op_i   (inv_op_i),
        .inv_asid_i (inv_asid_i),
        .inv_vaddr_i(inv_vaddr_i)
    );

    // 4M pages keep 22 offset bits
    assign tlb_paddr = (tlb_ps == 6'(`MMU_PS_4M)) ? {tlb_ppn[19:10], in_req_i.vaddr[21:0]}
                                                  : {tlb_ppn, in_req_i.vaddr[11:0]};

    always_comb begin
        resp_d.paddr = in_req_i.vaddr;
        resp_d.fault = mmu_pkg::fault_none;
        if (pg_mode) begin
            if (dmw0_hit) begin
                resp_d.paddr = {csr_dmw0_i[`MMU_DMW_PSEG], in_req_i.vaddr[28:0]};
            end else if (dmw1_hit) begin
                resp_d.paddr = {csr_dmw1_i[`MMU_DMW_PSEG], in_req_i.vaddr[28:0]};
            end else begin
                // faults in priority order, paddr zeroed on any of them
                resp_d.paddr = '0;
                if (!tlb_found) begin
                    resp_d.fault = mmu_pkg::fault_refill;
                end else if (!tlb_v) begin
                    resp_d.fault = mmu_pkg::fault_invalid;
                end else if (in_req_i.plv > tlb_plv) begin
                    resp_d.fault = mmu_pkg::fault_priv;
                end else if (in_req_i.is_store && !tlb_d) begin
                    resp_d.fault = mmu_pkg::fault_modify;
                end else begin
                    resp_d.paddr = tlb_paddr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        out_resp_q <= resp_d;
    end

    assign out_valid_o = out_valid_q;
    assign out_resp_o  = out_resp_q;

endmodule

// File: design/credit_fifo.sv
module credit_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH = 4,
    parameter int  OUT_CREDITS = 4
) (
    input  logic     clk,
    input  logic     reset_i,
    // upstream side
    input  logic     push_i,
    input  payload_t push_data_i,
    output logic     credit_o,
    // downstream side
    output logic     valid_o,
    output payload_t data_o,
    input  logic     credit_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    // downstream never returns more than it was handed
    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    payload_t            mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;
    logic [CRED_W-1:0]   credits_q;
    logic                pop;

    // pop as soon as there is data and a place for it downstream
    assign pop = (count_q != '0) && (credits_q != '0);

    assign valid_o  = pop;
    assign data_o   = mem[rd_ptr_q];
    assign credit_o = pop;

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            credits_q <= CRED_W'(OUT_CREDITS);
        end else begin
            if (push_i) begin
                if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            count_q   <= count_q + CNT_W'(push_i) - CNT_W'(pop);
            // one spent per pop, one back per grant
            credits_q <= credits_q + CRED_W'(credit_i) - CRED_W'(pop);
        end
    end

endmodule

// File: design/mmu_cfg.svh
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// number of tlb entries, fully associative
`define MMU_TLB_ENTRIES 16

// fifo depths on both sides of the translate stage
`define MMU_REQ_DEPTH 4
`define MMU_RESP_DEPTH 4

// page size codes as held in the entry ps field
`define MMU_PS_4K 12
`define MMU_PS_4M 22

// direct mapping window register fields
`define MMU_DMW_PLV0 0
`define MMU_DMW_PLV3 3
`define MMU_DMW_PSEG 27:25
`define MMU_DMW_VSEG 31:29

`endif

// File: design/mmu_pkg.sv
package mmu_pkg;

    // translation result, none means paddr is usable
    typedef enum logic [2:0] {
        fault_none    = 3'd0,
        fault_refill  = 3'd1,
        fault_invalid = 3'd2,
        fault_modify  = 3'd3,
        fault_priv    = 3'd4
    } fault_e;

    // request as it sits in the input fifo
    typedef struct packed {
        logic [31:0] vaddr;
        logic        is_store;
        logic [1:0]  plv;
    } xlat_req_t;

    // response as it sits in the output fifo
    typedef struct packed {
        logic [31:0] paddr;
        fault_e      fault;
    } xlat_resp_t;

    // one tlb entry, covering an even/odd page pair
    typedef struct packed {
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic        g;
        logic [9:0]  asid;
        logic [19:0] ppn0;
        logic [19:0] ppn1;
        logic        v0;
        logic        v1;
        logic        d0;
        logic        d1;
        logic [1:0]  plv0;
        logic [1:0]  plv1;
    } tlb_entry_t;

endpackage

// File: design/mmu_top.sv
`include "mmu_cfg.svh"

module mmu_top (
    input  logic                                clk,
    input  logic                                reset_i,
    // request side
    input  logic                                req_valid_i,
    input  logic [31:0]                         req_vaddr_i,
    input  logic                                req_is_store_i,
    input  logic [1:0]                          req_plv_i,
    output logic                                req_credit_o,
    // response side
    output logic                                resp_valid_o,
    output logic [31:0]                         resp_paddr_o,
    output mmu_pkg::fault_e                     resp_fault_o,
    input  logic                                resp_credit_i,
    // csr levels
    input  logic                                csr_da_i,
    input  logic                                csr_pg_i,
    input  logic [31:0]                         csr_dmw0_i,
    input  logic [31:0]                         csr_dmw1_i,
    input  logic [9:0]                          asid_i,
    // tlb write
    input  logic                                tlb_we_i,
    input  logic [$clog2(`MMU_TLB_ENTRIES)-1:0] tlb_w_index_i,
    input  logic [18:0]                         tlb_vppn_i,
    input  logic [5:0]                          tlb_ps_i,
    input  logic                                tlb_g_i,
    input  logic [9:0]                          tlb_asid_i,
    input  logic [19:0]                         tlb_ppn0_i,
    input  logic [19:0]                         tlb_ppn1_i,
    input  logic                                tlb_v0_i,
    input  logic                                tlb_v1_i,
    input  logic                                tlb_d0_i,
    input  logic                                tlb_d1_i,
    input  logic [1:0]                          tlb_plv0_i,
    input  logic [1:0]                          tlb_plv1_i,
    // invalidate
    input  logic                                inv_en_i,
    input  logic [4:0]                          inv_op_i,
    input  logic [9:0]                          inv_asid_i,
    input  logic [31:0]                         inv_vaddr_i
);

    mmu_pkg::xlat_req_t  req_in;
    mmu_pkg::xlat_req_t  req_popped;
    logic                req_pop_valid;
    mmu_pkg::tlb_entry_t w_entry;
    logic                xlat_valid;
    mmu_pkg::xlat_resp_t xlat_resp;
    logic                resp_credit_int;
    mmu_pkg::xlat_resp_t resp_out;

    assign req_in = '{vaddr: req_vaddr_i, is_store: req_is_store_i, plv: req_plv_i};

    assign w_entry = '{
        vppn: tlb_vppn_i, ps: tlb_ps_i, g: tlb_g_i, asid: tlb_asid_i,
        ppn0: tlb_ppn0_i, ppn1: tlb_ppn1_i, v0: tlb_v0_i, v1: tlb_v1_i,
        d0: tlb_d0_i, d1: tlb_d1_i, plv0: tlb_plv0_i, plv1: tlb_plv1_i
    };

    // internal credits bound what sits in translate plus output fifo
    credit_fifo #(
        .payload_t  (mmu_pkg::xlat_req_t),
        .DEPTH      (`MMU_REQ_DEPTH),
        .OUT_CREDITS(`MMU_RESP_DEPTH)
    ) req_fifo_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .push_i     (req_valid_i),
        .push_data_i(req_in),
        .credit_o   (req_credit_o),
        .valid_o    (req_pop_valid),
        .data_o     (req_popped),
        .credit_i   (resp_credit_int)
    );

    addr_translate xlat_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .in_valid_i   (req_pop_valid),
        .in_req_i     (req_popped),
        .csr_da_i     (csr_da_i),
        .csr_pg_i     (csr_pg_i),
        .csr_dmw0_i   (csr_dmw0_i),
        .csr_dmw1_i   (csr_dmw1_i),
        .asid_i       (asid_i),
        .tlb_we_i     (tlb_we_i),
        .tlb_w_index_i(tlb_w_index_i),
        .tlb_w_entry_i(w_entry),
        .inv_en_i     (inv_en_i),
        .inv_op_i     (inv_op_i),
        .inv_asid_i   (inv_asid_i),
        .inv_vaddr_i  (inv_vaddr_i),
        .out_valid_o  (xlat_valid),
        .out_resp_o   (xlat_resp)
    );

    credit_fifo #(
        .payload_t  (mmu_pkg::xlat_resp_t),
        .DEPTH      (`MMU_RESP_DEPTH),
        .OUT_CREDITS(`MMU_RESP_DEPTH)
    ) resp_fifo_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .push_i     (xlat_valid),
        .push_data_i(xlat_resp),
        .credit_o   (resp_credit_int),
        .valid_o    (resp_valid_o),
        .data_o     (resp_out),
        .credit_i   (resp_credit_i)
    );

    assign resp_paddr_o = resp_out.paddr;
    assign resp_fault_o = resp_out.fault;

endmodule

// File: design/tlb_array.sv
`include "mmu_cfg.svh"

module tlb_array (
    input  logic                                clk,
    input  logic                                reset_i,
    // search
    input  logic [31:0]                         s_vaddr_i,
    input  logic [9:0]                          s_asid_i,
    output logic                                s_found_o,
    output logic [5:0]                          s_ps_o,
    output logic [19:0]                         s_ppn_o,
    output logic                                s_v_o,
    output logic                                s_d_o,
    output logic [1:0]                          s_plv_o,
    // write
    input  logic                                we_i,
    input  logic [$clog2(`MMU_TLB_ENTRIES)-1:0] w_index_i,
    input  mmu_pkg::tlb_entry_t                 w_entry_i,
    // invalidate
    input  logic                                inv_en_i,
    input  logic [4:0]                          inv_op_i,
    input  logic [9:0]                          inv_asid_i,
    input  logic [31:0]                         inv_vaddr_i
);

    localparam int ENTRIES = `MMU_TLB_ENTRIES;
    localparam int IDX_W = $clog2(ENTRIES);

    // entries hold no reset, only the valid bits do
    mmu_pkg::tlb_entry_t entries_q [ENTRIES];
    logic [ENTRIES-1:0]  valid_q;
    logic [ENTRIES-1:0]  hit;
    logic [ENTRIES-1:0]  inv_hit;
    logic                found;
    logic [IDX_W-1:0]    sel;
    mmu_pkg::tlb_entry_t sel_entry;
    logic                odd;

    // 4M pages compare only the upper nine vppn bits
    function automatic logic vpn_match(mmu_pkg::tlb_entry_t e, logic [31:0] va);
        if (e.ps == 6'(`MMU_PS_4M)) begin
            return e.vppn[18:10] == va[31:23];
        end
        return e.vppn == va[31:13];
    endfunction

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            hit[i] = valid_q[i]
                && (entries_q[i].g || (entries_q[i].asid == s_asid_i))
                && vpn_match(entries_q[i], s_vaddr_i);
        end
    end

    // lowest index wins, though only one should ever hit
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                found = 1'b1;
                sel   = IDX_W'(i);
            end
        end
    end

    assign sel_entry = entries_q[sel];
    // odd half chosen by the bit just above the page offset
    assign odd = (sel_entry.ps == 6'(`MMU_PS_4M)) ? s_vaddr_i[22] : s_vaddr_i[12];

    assign s_found_o = found;
    assign s_ps_o    = found ? sel_entry.ps : '0;
    assign s_ppn_o   = !found ? '0 : (odd ? sel_entry.ppn1 : sel_entry.ppn0);
    assign s_v_o     = found && (odd ? sel_entry.v1 : sel_entry.v0);
    assign s_d_o     = found && (odd ? sel_entry.d1 : sel_entry.d0);
    assign s_plv_o   = !found ? '0 : (odd ? sel_entry.plv1 : sel_entry.plv0);

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            case (inv_op_i)
                // everything
                5'd0: inv_hit[i] = 1'b1;
                // non-global entries of one asid
                5'd4: inv_hit[i] = !entries_q[i].g && (entries_q[i].asid == inv_asid_i);
                // global or asid match, and page match
                5'd6: inv_hit[i] = (entries_q[i].g || (entries_q[i].asid == inv_asid_i))
                                   && vpn_match(entries_q[i], inv_vaddr_i);
                default: inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            entries_q[w_index_i] <= w_entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            if (inv_en_i) begin
                valid_q <= valid_q & ~inv_hit;
            end
            // a write in the same cycle still lands valid
            if (we_i) begin
                valid_q[w_index_i] <= 1'b1;
            end
        end
    end

endmodule

// File: list.f
+incdir+design
design/mmu_pkg.sv
design/credit_fifo.sv
design/tlb_array.sv
design/addr_translate.sv
design/mmu_top.sv
tb/tb_clock.sv
tb/mmu_checker.sv
tb/mmu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mmu testbench, pass only if the log holds the pass line
rm -rf obj_dir
verilator --binary --timing -f list.f --top-module mmu_tb -o mmu_sim > build.log 2>&1 \
    && ./obj_dir/mmu_sim > sim.log 2>&1 \
    && grep -qx "Test passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }

// File: tb/mmu_checker.sv
`include "mmu_cfg.svh"

module mmu_checker (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            req_valid_i,
    input  logic            req_credit_i,
    input  logic            resp_valid_i,
    input  logic [31:0]     resp_paddr_i,
    input  mmu_pkg::fault_e resp_fault_i,
    input  logic            resp_credit_i,
    output int              mismatch_cnt_o,
    output int              other_cnt_o,
    output int              pending_o,
    output int              seen_o
);

    logic [31:0]     exp_paddr_q[$];
    mmu_pkg::fault_e exp_fault_q[$];
    int              credits;
    int              req_sent_q;
    int              req_returned_q;

    assign pending_o = exp_paddr_q.size();

    task automatic expect_resp(input logic [31:0] paddr, input mmu_pkg::fault_e fault);
        exp_paddr_q.push_back(paddr);
        exp_fault_q.push_back(fault);
    endtask

    // work still open once the stimulus is done
    function automatic int end_of_run_errors();
        int errs;
        errs = exp_paddr_q.size();
        if (exp_paddr_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_paddr_q.size());
        end
        if (req_returned_q != req_sent_q) begin
            $display("request credits returned %0d but %0d requests were sent",
                     req_returned_q, req_sent_q);
            errs++;
        end
        return errs;
    endfunction

    always @(posedge clk) begin
        logic [31:0]     exp_paddr;
        mmu_pkg::fault_e exp_fault;
        int              add_mismatch;
        int              add_other;
        add_mismatch = 0;
        add_other = 0;
        if (reset_i) begin
            credits        <= `MMU_RESP_DEPTH;
            mismatch_cnt_o <= 0;
            other_cnt_o    <= 0;
            seen_o         <= 0;
            req_sent_q     <= 0;
            req_returned_q <= 0;
        end else begin
            if (resp_valid_i) begin
                // the output fifo may only send against a granted credit
                if (credits == 0) begin
                    $display("response sent while the consumer held no credit");
                    add_other++;
                end
                if (exp_paddr_q.size() == 0) begin
                    $display("response arrived with no expected result queued");
                    add_other++;
                end else begin
                    exp_paddr = exp_paddr_q.pop_front();
                    exp_fault = exp_fault_q.pop_front();
                    if (resp_paddr_i !== exp_paddr) begin
                        $display("mismatch resp_paddr_o: got %h expected %h",
                                 resp_paddr_i, exp_paddr);
                        add_mismatch++;
                    end
                    if (resp_fault_i !== exp_fault) begin
                        $display("mismatch resp_fault_o: got %h expected %h",
                                 resp_fault_i, exp_fault);
                        add_mismatch++;
                    end
                end
                seen_o <= seen_o + 1;
            end
            // requests pushed against credit pulses handed back
            req_sent_q     <= req_sent_q + int'(req_valid_i);
            req_returned_q <= req_returned_q + int'(req_credit_i);
            credits        <= credits + int'(resp_credit_i) - int'(resp_valid_i);
            mismatch_cnt_o <= mismatch_cnt_o + add_mismatch;
            other_cnt_o    <= other_cnt_o + add_other;
        end
    end

endmodule

// File: tb/mmu_tb.sv
`include "mmu_cfg.svh"

module mmu_tb;

    typedef enum logic [2:0] {act_cfg, act_write, act_inv, act_xlat, act_gap, act_bp} act_e;

    // addr is vaddr or asid, arg0..arg2 depend on the kind
    typedef struct packed {
        act_e                kind;
        logic [31:0]         addr;
        logic [31:0]         arg0;
        logic [31:0]         arg1;
        logic [31:0]         arg2;
        mmu_pkg::tlb_entry_t ent;
        mmu_pkg::fault_e     fault;
    } row_t;

    logic clk;
    logic reset;
    logic req_valid, req_store, req_credit, resp_valid, resp_credit;
    logic [31:0] req_vaddr, resp_paddr, csr_dmw0, csr_dmw1, inv_vaddr;
    logic [1:0] req_plv;
    mmu_pkg::fault_e resp_fault;
    logic csr_da, csr_pg, tlb_we, inv_en, backpressure;
    logic [9:0] asid, inv_asid;
    logic [$clog2(`MMU_TLB_ENTRIES)-1:0] tlb_index;
    mmu_pkg::tlb_entry_t w_ent;
    logic [4:0] inv_op;
    int chk_mismatch, chk_other, chk_pending, chk_seen;
    int req_sent, req_returned, resp_granted;
    row_t rows[$];

    tb_clock #(.PERIOD(20)) clock_i (.clk_o(clk), .reset_o(reset));

    mmu_top dut_i (
        .clk(clk), .reset_i(reset),
        .req_valid_i(req_valid), .req_vaddr_i(req_vaddr), .req_is_store_i(req_store),
        .req_plv_i(req_plv), .req_credit_o(req_credit),
        .resp_valid_o(resp_valid), .resp_paddr_o(resp_paddr), .resp_fault_o(resp_fault),
        .resp_credit_i(resp_credit),
        .csr_da_i(csr_da), .csr_pg_i(csr_pg), .csr_dmw0_i(csr_dmw0), .csr_dmw1_i(csr_dmw1),
        .asid_i(asid), .tlb_we_i(tlb_we), .tlb_w_index_i(tlb_index),
        .tlb_vppn_i(w_ent.vppn), .tlb_ps_i(w_ent.ps), .tlb_g_i(w_ent.g),
        .tlb_asid_i(w_ent.asid), .tlb_ppn0_i(w_ent.ppn0), .tlb_ppn1_i(w_ent.ppn1),
        .tlb_v0_i(w_ent.v0), .tlb_v1_i(w_ent.v1), .tlb_d0_i(w_ent.d0), .tlb_d1_i(w_ent.d1),
        .tlb_plv0_i(w_ent.plv0), .tlb_plv1_i(w_ent.plv1),
        .inv_en_i(inv_en), .inv_op_i(inv_op), .inv_asid_i(inv_asid), .inv_vaddr_i(inv_vaddr)
    );

    mmu_checker chk_i (
        .clk(clk), .reset_i(reset), .req_valid_i(req_valid), .req_credit_i(req_credit),
        .resp_valid_i(resp_valid), .resp_paddr_i(resp_paddr),
        .resp_fault_i(resp_fault), .resp_credit_i(resp_credit),
        .mismatch_cnt_o(chk_mismatch), .other_cnt_o(chk_other),
        .pending_o(chk_pending), .seen_o(chk_seen)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic row_t cfg_row(logic da, logic pg, logic [31:0] dmw0,
                                     logic [31:0] dmw1, logic [9:0] id);
        row_t r;
        r = '0;
        r.kind = act_cfg;
        r.addr = {22'd0, id};
        r.arg0 = {30'd0, da, pg};
        r.arg1 = dmw0;
        r.arg2 = dmw1;
        return r;
    endfunction

    // vd is v0 v1 d0 d1, plv is plv0 then plv1
    function automatic row_t write_row(logic [3:0] idx, logic [31:0] va, logic [5:0] ps,
                                       logic g, logic [9:0] id, logic [19:0] ppn0,
                                       logic [19:0] ppn1, logic [3:0] vd, logic [3:0] plv);
        row_t r;
        r = '0;
        r.kind = act_write;
        r.arg0 = {28'd0, idx};
        r.ent = '{vppn: va[31:13], ps: ps, g: g, asid: id, ppn0: ppn0, ppn1: ppn1,
                  v0: vd[3], v1: vd[2], d0: vd[1], d1: vd[0], plv0: plv[3:2], plv1: plv[1:0]};
        return r;
    endfunction

    function automatic row_t inv_row(logic [4:0] op, logic [9:0] id, logic [31:0] va);
        row_t r;
        r = '0;
        r.kind = act_inv;
        r.addr = va;
        r.arg0 = {27'd0, op};
        r.arg1 = {22'd0, id};
        return r;
    endfunction

    function automatic row_t xlat_row(logic [31:0] va, logic st, logic [1:0] plv,
                                      logic [31:0] pa, mmu_pkg::fault_e f);
        row_t r;
        r = '0;
        r.kind = act_xlat;
        r.addr = va;
        r.arg0 = {29'd0, st, plv};
        r.arg1 = pa;
        r.fault = f;
        return r;
    endfunction

    function automatic row_t misc_row(act_e kind, logic [31:0] n);
        row_t r;
        r = '0;
        r.kind = kind;
        r.arg0 = n;
        return r;
    endfunction

    task automatic build_table();
        logic [31:0] off;
        // direct mode under any privilege
        rows.push_back(cfg_row(1'b1, 1'b0, 32'h0, 32'h0, 10'd1));
        rows.push_back(xlat_row(32'h1234_5678, 0, 2'd0, 32'h1234_5678, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'hdead_beef, 1, 2'd3, 32'hdead_beef, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h8765_4320, 0, 2'd1, 32'h8765_4320, mmu_pkg::fault_none));
        // dmw0 vseg 5 pseg 0 plv0, dmw1 vseg 4 pseg 1 plv3
        rows.push_back(cfg_row(1'b0, 1'b1, 32'ha000_0001, 32'h8200_0008, 10'd1));
        rows.push_back(xlat_row(32'ha001_2344, 0, 2'd0, 32'h0001_2344, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h8765_4320, 1, 2'd3, 32'h2765_4320, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h8765_4320, 0, 2'd0, 32'h0, mmu_pkg::fault_refill));
        rows.push_back(xlat_row(32'ha001_2344, 0, 2'd3, 32'h0, mmu_pkg::fault_refill));
        rows.push_back(write_row(4'd0, 32'h0040_0000, 6'd12, 0, 10'd1, 20'h12345, 20'h54321,
                                 4'b1111, 4'b1111));
        rows.push_back(write_row(4'd1, 32'h1000_0000, 6'd22, 1, 10'd7, 20'habc00, 20'h13400,
                                 4'b1111, 4'b1111));
        rows.push_back(write_row(4'd2, 32'h0060_0000, 6'd12, 0, 10'd2, 20'h00777, 20'h00778,
                                 4'b1111, 4'b1111));
        // even half not valid, odd half clean and kernel only
        rows.push_back(write_row(4'd3, 32'h0080_0000, 6'd12, 0, 10'd1, 20'h11111, 20'h22222,
                                 4'b0110, 4'b1100));
        rows.push_back(misc_row(act_gap, 32'd3));
        rows.push_back(xlat_row(32'h0040_0abc, 0, 2'd3, 32'h1234_5abc, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h0040_1def, 1, 2'd3, 32'h5432_1def, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h1012_3456, 0, 2'd0, 32'habd2_3456, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h1052_0000, 1, 2'd3, 32'h1352_0000, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h0060_0123, 0, 2'd0, 32'h0, mmu_pkg::fault_refill));
        rows.push_back(xlat_row(32'h0080_0010, 0, 2'd0, 32'h0, mmu_pkg::fault_invalid));
        rows.push_back(xlat_row(32'h0080_1010, 0, 2'd3, 32'h0, mmu_pkg::fault_priv));
        rows.push_back(xlat_row(32'h0080_1010, 1, 2'd0, 32'h0, mmu_pkg::fault_modify));
        rows.push_back(xlat_row(32'h0080_1010, 0, 2'd0, 32'h2222_2010, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h00c0_0000, 0, 2'd0, 32'h0, mmu_pkg::fault_refill));
        rows.push_back(inv_row(5'd6, 10'd1, 32'h0040_0000));
        rows.push_back(xlat_row(32'h0040_0abc, 0, 2'd3, 32'h0, mmu_pkg::fault_refill));
        rows.push_back(xlat_row(32'h0040_1def, 0, 2'd3, 32'h0, mmu_pkg::fault_refill));
        rows.push_back(xlat_row(32'h1012_3456, 0, 2'd0, 32'habd2_3456, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h0080_1010, 0, 2'd0, 32'h2222_2010, mmu_pkg::fault_none));
        rows.push_back(inv_row(5'd4, 10'd1, 32'h0));
        rows.push_back(xlat_row(32'h0080_1010, 0, 2'd0, 32'h0, mmu_pkg::fault_refill));
        rows.push_back(xlat_row(32'h1052_0000, 1, 2'd3, 32'h1352_0000, mmu_pkg::fault_none));
        rows.push_back(cfg_row(1'b0, 1'b1, 32'ha000_0001, 32'h8200_0008, 10'd2));
        rows.push_back(xlat_row(32'h0060_0123, 0, 2'd0, 32'h0077_7123, mmu_pkg::fault_none));
        rows.push_back(xlat_row(32'h0060_1456, 0, 2'd0, 32'h0077_8456, mmu_pkg::fault_none));
        rows.push_back(inv_row(5'd0, 10'd0, 32'h0));
        rows.push_back(xlat_row(32'h1012_3456, 0, 2'd0, 32'h0, mmu_pkg::fault_refill));
        rows.push_back(xlat_row(32'h0060_0123, 0, 2'd0, 32'h0, mmu_pkg::fault_refill));
        rows.push_back(xlat_row(32'ha001_2344, 0, 2'd0, 32'h0001_2344, mmu_pkg::fault_none));
        // burst of 16 against a slow consumer
        rows.push_back(write_row(4'd5, 32'h0200_0000, 6'd12, 1, 10'd0, 20'h40000, 20'h40001,
                                 4'b1111, 4'b1111));
        rows.push_back(misc_row(act_bp, 32'd1));
        for (int i = 0; i < 16; i++) begin
            off = 32'(i * 8) | (32'(i % 2) << 12);
            rows.push_back(xlat_row(32'h0200_0000 | off, 1'(i / 2), 2'd3, 32'h4000_0000 | off,
                                    mmu_pkg::fault_none));
        end
        rows.push_back(misc_row(act_bp, 32'd0));
        rows.push_back(misc_row(act_gap, 32'd2));
    endtask

    task automatic wait_drain();
        while (chk_pending != 0) @(negedge clk);
    endtask

    task automatic apply_row(input row_t r);
        case (r.kind)
            act_cfg: begin
                wait_drain();
                csr_da = r.arg0[1];
                csr_pg = r.arg0[0];
                csr_dmw0 = r.arg1;
                csr_dmw1 = r.arg2;
                asid = r.addr[9:0];
                @(negedge clk);
            end
            act_write: begin
                wait_drain();
                tlb_we = 1'b1;
                tlb_index = r.arg0[3:0];
                w_ent = r.ent;
                @(negedge clk);
                tlb_we = 1'b0;
            end
            act_inv: begin
                wait_drain();
                inv_en = 1'b1;
                inv_op = r.arg0[4:0];
                inv_asid = r.arg1[9:0];
                inv_vaddr = r.addr;
                @(negedge clk);
                inv_en = 1'b0;
            end
            act_xlat: begin
                // only send while holding a request credit
                while (`MMU_REQ_DEPTH + req_returned - req_sent == 0) @(negedge clk);
                chk_i.expect_resp(r.arg1, r.fault);
                req_valid = 1'b1;
                req_vaddr = r.addr;
                req_store = r.arg0[2];
                req_plv = r.arg0[1:0];
                req_sent++;
                @(negedge clk);
                req_valid = 1'b0;
            end
            act_gap: repeat (r.arg0) @(negedge clk);
            default: backpressure <= r.arg0[0];
        endcase
    endtask

    always @(posedge clk) begin
        if (reset) begin
            req_returned <= 0;
        end else if (req_credit) begin
            req_returned <= req_returned + 1;
        end
    end

    // response credits go back one per response seen and wait on the lfsr under back-pressure
    initial begin
        logic [31:0] lfsr;
        logic        grant;
        lfsr = 32'hf10b795d;
        resp_credit = 1'b0;
        resp_granted = 0;
        forever begin
            @(negedge clk);
            grant = 1'b0;
            if (!reset && (chk_seen > resp_granted)) begin
                if (backpressure) begin
                    grant = lfsr[0];
                    lfsr = lfsr_step(lfsr);
                end else begin
                    grant = 1'b1;
                end
            end
            resp_credit = grant;
            if (grant) resp_granted++;
        end
    end

    initial begin
        int limit;
        int cycles;
        cycles = 0;
        @(posedge clk);
        limit = 40 * rows.size() + 200;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("errors: %0d mismatch, %0d other", chk_mismatch, chk_other + 1);
        $display("Test failed");
        $finish;
    end

    initial begin
        int late_errors;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_store = 1'b0;
        req_plv = '0;
        csr_da = 1'b1;
        csr_pg = 1'b0;
        csr_dmw0 = '0;
        csr_dmw1 = '0;
        asid = '0;
        tlb_we = 1'b0;
        tlb_index = '0;
        w_ent = '0;
        inv_en = 1'b0;
        inv_op = '0;
        inv_asid = '0;
        inv_vaddr = '0;
        backpressure <= 1'b0;
        req_sent = 0;
        build_table();
        wait (reset == 1'b0);
        @(negedge clk);
        foreach (rows[i]) apply_row(rows[i]);
        wait_drain();
        repeat (5) @(negedge clk);
        late_errors = chk_i.end_of_run_errors();
        $display("errors: %0d mismatch, %0d other", chk_mismatch, chk_other + late_errors);
        if (chk_mismatch + chk_other + late_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // held high over the first two rising edges
    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule
